//--- design/soc_pkg.sv
// address map, baud divider and memory depth are fixed here; one request in flight on the bus
package soc_pkg;

    //////////////////////////////
    // widths and depth
    //////////////////////////////
    localparam int addr_w      = 32;
    localparam int data_w      = 32;
    localparam int strb_w      = 4;
    localparam int bram_words  = 256;
    localparam int bram_addr_w = 8;

    //////////////////////////////
    // address map
    //////////////////////////////
    // same address for tx write and rx pop
    localparam logic [addr_w-1:0] uart_tx_addr  = 32'h1000_0000;
    localparam logic [addr_w-1:0] uart_lsr_addr = 32'h1000_0005;
    localparam logic [addr_w-1:0] led_addr      = 32'h1200_0000;
    localparam logic [addr_w-1:0] freq_addr     = 32'h1100_0004;

    localparam logic [data_w-1:0] system_clk_hz = 32'd10_000_000;

    // baud timing in clock cycles
    localparam int clks_per_bit = 16;
    localparam int baud_cnt_w   = $clog2(clks_per_bit);
    localparam logic [baud_cnt_w-1:0] baud_last = baud_cnt_w'(clks_per_bit - 1);
    localparam logic [baud_cnt_w-1:0] baud_half = baud_cnt_w'(clks_per_bit / 2 - 1);

    localparam logic [7:0] led_reset = 8'hF9;

    // line-status layout
    localparam logic [data_w-1:0] rx_empty_word    = '1;
    localparam logic [data_w-1:0] lsr_tx_idle_bits = 32'h0000_6000;
    localparam int                lsr_rx_avail_bit = 8;

    //////////////////////////////
    // bus types
    //////////////////////////////
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wstrb;
    } bus_req_t;

    typedef enum logic [2:0] {
        tgt_none,
        tgt_bram,
        tgt_led,
        tgt_uart_data,
        tgt_uart_lsr,
        tgt_freq
    } bus_target_e;

    // one accepted access, active for a single cycle
    typedef struct packed {
        logic                   active;
        bus_target_e            target;
        logic                   write;
        logic [bram_addr_w-1:0] index;
        logic [strb_w-1:0]      strb;
        logic [data_w-1:0]      wdata;
    } bus_access_t;

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } uart_state_e;

endpackage

//--- design/soc_bus_decode.sv
// req must stay stable while valid is high; every target answers with ready one cycle later
`timescale 1ns/10ps

module soc_bus_decode (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 valid,
    input  soc_pkg::bus_req_t    req,
    output logic                 ready,
    output soc_pkg::bus_access_t acc,
    output soc_pkg::bus_target_e resp_target
);

    soc_pkg::bus_target_e target;

    //////////////////////////////
    // address decode
    //////////////////////////////
    always_comb begin
        if (req.addr < (soc_pkg::bram_words * 4)) begin
            target = soc_pkg::tgt_bram;
        end else if (req.addr == soc_pkg::uart_tx_addr) begin
            target = soc_pkg::tgt_uart_data;
        end else if (req.addr == soc_pkg::uart_lsr_addr) begin
            target = soc_pkg::tgt_uart_lsr;
        end else if (req.addr == soc_pkg::led_addr) begin
            target = soc_pkg::tgt_led;
        end else if (req.addr == soc_pkg::freq_addr) begin
            target = soc_pkg::tgt_freq;
        end else begin
            target = soc_pkg::tgt_none;
        end
    end

    // strobe held off by the pending ready so one request gives one access
    always_comb begin
        acc.active = valid && !ready;
        acc.target = target;
        acc.write  = |req.wstrb;
        acc.index  = req.addr[soc_pkg::bram_addr_w+1:2];
        acc.strb   = req.wstrb;
        acc.wdata  = req.wdata;
    end

    //////////////////////////////
    // response timing
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ready       <= 1'b0;
            resp_target <= soc_pkg::tgt_none;
        end else begin
            ready       <= acc.active;
            resp_target <= acc.active ? target : soc_pkg::tgt_none;
        end
    end

endmodule

//--- design/soc_bram.sv
// contents are undefined after power-up; a write access returns the word as it was before the write
`timescale 1ns/10ps

module soc_bram (
    input  logic                       clk,
    input  soc_pkg::bus_access_t       acc,
    output logic [soc_pkg::data_w-1:0] mem_rdata
);

    logic [soc_pkg::data_w-1:0] mem [soc_pkg::bram_words];
    logic                       hit;
    logic                       wr_hit;

    assign hit    = acc.active && (acc.target == soc_pkg::tgt_bram);
    assign wr_hit = hit && acc.write;

    //////////////////////////////
    // byte lane writes
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_hit) begin
            for (int i = 0; i < soc_pkg::strb_w; i++) begin
                if (acc.strb[i]) begin
                    mem[acc.index][8*i +: 8] <= acc.wdata[8*i +: 8];
                end
            end
        end
    end

    // read port, captured on the access edge
    always_ff @(posedge clk) begin
        if (hit) begin
            mem_rdata <= mem[acc.index];
        end
    end

endmodule

//--- design/soc_uart_tx.sv
// 8N1 only, no flow control; a write while a frame is in progress is dropped, poll tx_busy first
`timescale 1ns/10ps

module soc_uart_tx (
    input  logic                 clk,
    input  logic                 resetn,
    input  soc_pkg::bus_access_t acc,
    output logic                 uart_tx,
    output logic                 tx_busy
);

    soc_pkg::uart_state_e             state;
    logic [soc_pkg::baud_cnt_w-1:0]   cnt;
    logic [2:0]                       bit_idx;
    logic [7:0]                       shreg;
    logic                             load;
    logic                             bit_end;
    logic                             shift;

    assign load    = acc.active && acc.write && (acc.target == soc_pkg::tgt_uart_data) &&
                     (state == soc_pkg::st_idle);
    assign bit_end = (cnt == soc_pkg::baud_last);
    // next data bit goes out at the end of start and of each data bit
    assign shift   = bit_end && ((state == soc_pkg::st_start) || (state == soc_pkg::st_data));
    assign tx_busy = (state != soc_pkg::st_idle);

    //////////////////////////////
    // frame sequencer
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= soc_pkg::st_idle;
            cnt     <= '0;
            bit_idx <= '0;
            uart_tx <= 1'b1;
        end else begin
            cnt <= bit_end ? '0 : cnt + 1'b1;
            unique case (state)
                soc_pkg::st_idle: begin
                    cnt <= '0;
                    if (load) begin
                        state   <= soc_pkg::st_start;
                        uart_tx <= 1'b0;
                    end
                end
                soc_pkg::st_start: begin
                    if (bit_end) begin
                        state   <= soc_pkg::st_data;
                        bit_idx <= '0;
                        uart_tx <= shreg[0];
                    end
                end
                soc_pkg::st_data: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state   <= soc_pkg::st_stop;
                            uart_tx <= 1'b1;
                        end else begin
                            uart_tx <= shreg[0];
                        end
                    end
                end
                soc_pkg::st_stop: begin
                    if (bit_end) begin
                        state <= soc_pkg::st_idle;
                    end
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= acc.wdata[7:0];
        end else if (shift) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

endmodule

//--- design/soc_uart_rx.sv
// 8N1 only, one byte of holding; a byte that is not read in time is overwritten by the next one
`timescale 1ns/10ps

module soc_uart_rx (
    input  logic                 clk,
    input  logic                 resetn,
    input  soc_pkg::bus_access_t acc,
    input  logic                 uart_rx,
    output logic [7:0]           rx_byte,
    output logic                 rx_avail
);

    soc_pkg::uart_state_e           state;
    logic [soc_pkg::baud_cnt_w-1:0] cnt;
    logic [2:0]                     bit_idx;
    logic [7:0]                     shreg;
    logic                           rx_meta;
    logic                           rx_sync;
    logic                           rx_prev;
    logic                           start_edge;
    logic                           sample;
    logic                           done;
    logic                           pop;

    assign start_edge = rx_prev && !rx_sync;
    assign sample     = (state == soc_pkg::st_data) && (cnt == soc_pkg::baud_last);
    assign done       = (state == soc_pkg::st_stop) && (cnt == soc_pkg::baud_last) && rx_sync;
    assign pop        = acc.active && !acc.write && (acc.target == soc_pkg::tgt_uart_data);

    //////////////////////////////
    // line sync and sequencer
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            rx_prev  <= 1'b1;
            state    <= soc_pkg::st_idle;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_avail <= 1'b0;
        end else begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
            cnt     <= cnt + 1'b1;
            unique case (state)
                soc_pkg::st_idle: begin
                    cnt <= '0;
                    if (start_edge) begin
                        state <= soc_pkg::st_start;
                    end
                end
                soc_pkg::st_start: begin
                    // half a bit in, then whole bits land mid-bit
                    if (cnt == soc_pkg::baud_half) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? soc_pkg::st_idle : soc_pkg::st_data;
                    end
                end
                soc_pkg::st_data: begin
                    if (sample) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= soc_pkg::st_stop;
                        end
                    end
                end
                soc_pkg::st_stop: begin
                    if (cnt == soc_pkg::baud_last) begin
                        state <= soc_pkg::st_idle;
                    end
                end
            endcase
            // a fresh byte wins over a pop in the same cycle
            if (done) begin
                rx_avail <= 1'b1;
            end else if (pop) begin
                rx_avail <= 1'b0;
            end
        end
    end

    // data path
    always_ff @(posedge clk) begin
        if (sample) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
        if (done) begin
            rx_byte <= shreg;
        end
    end

endmodule

//--- design/soc_io_regs.sv
// rdata is only meaningful in the ready cycle; writes to the status and frequency words are ignored
`timescale 1ns/10ps

module soc_io_regs (
    input  logic                       clk,
    input  logic                       resetn,
    input  soc_pkg::bus_access_t       acc,
    input  soc_pkg::bus_target_e       resp_target,
    input  logic [soc_pkg::data_w-1:0] mem_rdata,
    input  logic [7:0]                 rx_byte,
    input  logic                       rx_avail,
    input  logic                       tx_busy,
    output logic [soc_pkg::data_w-1:0] rdata,
    output logic [7:0]                 led
);

    logic [soc_pkg::data_w-1:0] rx_word;
    logic [soc_pkg::data_w-1:0] lsr_word;
    logic                       uart_hit;

    assign uart_hit = acc.active && (acc.target == soc_pkg::tgt_uart_data);

    //////////////////////////////
    // led register
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!resetn) begin
            led <= soc_pkg::led_reset;
        end else if (acc.active && acc.write && (acc.target == soc_pkg::tgt_led)) begin
            led <= acc.wdata[7:0];
        end
    end

    // receive word, zero for a tx write
    always_ff @(posedge clk) begin
        if (uart_hit) begin
            if (acc.write) begin
                rx_word <= '0;
            end else begin
                rx_word <= rx_avail ? {24'b0, rx_byte} : soc_pkg::rx_empty_word;
            end
        end
    end

    // line status
    always_comb begin
        lsr_word = '0;
        if (!tx_busy) begin
            lsr_word = soc_pkg::lsr_tx_idle_bits;
        end
        lsr_word[soc_pkg::lsr_rx_avail_bit] = rx_avail;
    end

    //////////////////////////////
    // read return
    //////////////////////////////
    always_comb begin
        unique case (resp_target)
            soc_pkg::tgt_bram:      rdata = mem_rdata;
            soc_pkg::tgt_uart_data: rdata = rx_word;
            soc_pkg::tgt_uart_lsr:  rdata = lsr_word;
            soc_pkg::tgt_freq:      rdata = soc_pkg::system_clk_hz;
            default:                rdata = '0;
        endcase
    end

endmodule

//--- design/soc_top.sv
// bus master must hold valid and req until ready; uart has no flow control, poll the status word
`timescale 1ns/10ps

module soc_top (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       valid,
    input  soc_pkg::bus_req_t          req,
    output logic                       ready,
    output logic [soc_pkg::data_w-1:0] rdata,
    output logic                       uart_tx,
    input  logic                       uart_rx,
    output logic [7:0]                 led
);

    soc_pkg::bus_access_t       acc;
    soc_pkg::bus_target_e       resp_target;
    logic [soc_pkg::data_w-1:0] mem_rdata;
    logic [7:0]                 rx_byte;
    logic                       rx_avail;
    logic                       tx_busy;

    //////////////////////////////
    // bus front end
    //////////////////////////////
    soc_bus_decode u_decode (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .req         (req),
        .ready       (ready),
        .acc         (acc),
        .resp_target (resp_target)
    );

    soc_bram u_bram (
        .clk       (clk),
        .acc       (acc),
        .mem_rdata (mem_rdata)
    );

    //////////////////////////////
    // uart and io
    //////////////////////////////
    soc_uart_tx u_uart_tx (
        .clk     (clk),
        .resetn  (resetn),
        .acc     (acc),
        .uart_tx (uart_tx),
        .tx_busy (tx_busy)
    );

    soc_uart_rx u_uart_rx (
        .clk      (clk),
        .resetn   (resetn),
        .acc      (acc),
        .uart_rx  (uart_rx),
        .rx_byte  (rx_byte),
        .rx_avail (rx_avail)
    );

    soc_io_regs u_io_regs (
        .clk         (clk),
        .resetn      (resetn),
        .acc         (acc),
        .resp_target (resp_target),
        .mem_rdata   (mem_rdata),
        .rx_byte     (rx_byte),
        .rx_avail    (rx_avail),
        .tx_busy     (tx_busy),
        .rdata       (rdata),
        .led         (led)
    );

endmodule

//--- testbench/tb_clock.sv
// free-running clock, 100 ns period, starts low at time zero
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    localparam int half_period = 50;

    initial begin
        clk = 1'b0;
    end

    always #half_period clk = ~clk;

endmodule

//--- testbench/tb_soc_assert.sv
// bus handshake rules of the decoder; checks are off while resetn is low
`timescale 1ns/10ps

module tb_soc_assert (
    input logic                 clk,
    input logic                 resetn,
    input logic                 ready,
    input soc_pkg::bus_access_t acc
);

    // ready is a single-cycle pulse
    ready_one_cycle: assert property (
        @(posedge clk) disable iff (!resetn) ready |=> !ready
    ) else $error("ready stayed high for two cycles");

    // every ready answers an access strobe from the cycle before
    ready_after_access: assert property (
        @(posedge clk) disable iff (!resetn) ready |-> $past(acc.active)
    ) else $error("ready without a preceding access strobe");

    // no new access while the response is out
    no_access_in_ready: assert property (
        @(posedge clk) disable iff (!resetn) !(acc.active && ready)
    ) else $error("access strobe while ready is high");

endmodule

//--- testbench/tb_soc.sv
// loopback of uart_tx into uart_rx; memory is filled before random reads, so no X words are read
`timescale 1ns/10ps

module tb_soc;

    localparam int drive_delay    = 10;
    localparam int reset_cycles   = 8;
    localparam int mem_ops        = 200;
    localparam int uart_bytes     = 8;
    localparam int ready_wait_max = 16;
    localparam int poll_limit     = 200;
    // run takes about 2500 cycles so the limit leaves a wide margin
    localparam int cycle_limit    = 20000;

    logic                           clk;
    logic                           resetn;
    logic                           valid;
    soc_pkg::bus_req_t              req;
    logic                           ready;
    logic [soc_pkg::data_w-1:0]     rdata;
    logic                           uart_line;
    logic [7:0]                     led;

    logic [soc_pkg::data_w-1:0]     model [soc_pkg::bram_words];
    int                             word_errors;
    int                             led_errors;
    int                             latency_errors;
    int                             other_errors;
    int                             cycle_count;
    int unsigned                    seed_val;

    tb_clock u_clock (.clk(clk));

    soc_top u_soc_top (
        .clk     (clk),
        .resetn  (resetn),
        .valid   (valid),
        .req     (req),
        .ready   (ready),
        .rdata   (rdata),
        .uart_tx (uart_line),
        .uart_rx (uart_line),
        .led     (led)
    );

    bind soc_bus_decode tb_soc_assert u_bus_assert (
        .clk    (clk),
        .resetn (resetn),
        .ready  (ready),
        .acc    (acc)
    );

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic check_word(input logic [soc_pkg::data_w-1:0] got,
                              input logic [soc_pkg::data_w-1:0] exp, input string name);
        if (got !== exp) begin
            word_errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_led(input logic [7:0] got, input logic [7:0] exp, input string name);
        if (got !== exp) begin
            led_errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string name);
        if (got != exp) begin
            latency_errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // one request held until ready; returns the read data of the ready cycle
    task automatic bus_access(input logic [soc_pkg::addr_w-1:0] addr,
                              input logic [soc_pkg::data_w-1:0] wdata,
                              input logic [soc_pkg::strb_w-1:0] strb,
                              output logic [soc_pkg::data_w-1:0] rd);
        int lat;
        @(posedge clk);
        #drive_delay;
        valid     = 1'b1;
        req.addr  = addr;
        req.wdata = wdata;
        req.wstrb = strb;
        lat       = 0;
        rd        = '0;
        do begin
            @(posedge clk);
            #drive_delay;
            lat++;
        end while (!ready && lat < ready_wait_max);
        if (!ready) begin
            other_errors++;
            $display("error at %0t: no ready for address %h after %0d cycles", $time, addr, lat);
        end else begin
            rd = rdata;
            check_latency(lat, 1, "ready latency");
        end
        valid = 1'b0;
        req   = '0;
    endtask

    function automatic logic [soc_pkg::data_w-1:0] fill_word(input logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h5A, idx + 8'h33};
    endfunction

    function automatic logic [soc_pkg::addr_w-1:0] pick_unmapped_addr();
        logic [soc_pkg::addr_w-1:0] a;
        do begin
            a = $urandom;
        end while (a < 32'd1024 || a == soc_pkg::uart_tx_addr || a == soc_pkg::uart_lsr_addr ||
                   a == soc_pkg::led_addr || a == soc_pkg::freq_addr);
        return a;
    endfunction

    // watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run reached %0d cycles without finishing", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        logic [soc_pkg::data_w-1:0]      rd;
        logic [soc_pkg::data_w-1:0]      wd;
        logic [soc_pkg::strb_w-1:0]      st;
        logic [7:0]                      idx;
        logic [7:0]                      bval;
        int                              polls;
        int                              total;
        resetn         = 1'b0;
        valid          = 1'b0;
        req            = '0;
        word_errors    = 0;
        led_errors     = 0;
        latency_errors = 0;
        other_errors   = 0;
        cycle_count    = 0;
        seed_val       = $urandom(78353);
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        resetn = 1'b1;

        // state after reset
        check_led(led, soc_pkg::led_reset, "led");
        check_word({31'b0, uart_line}, 32'd1, "uart_tx");
        check_word({31'b0, ready}, 32'd0, "ready");

        // fill memory, then random traffic against the model
        for (int i = 0; i < soc_pkg::bram_words; i++) begin
            idx = 8'(i);
            bus_access({22'b0, idx, 2'b00}, fill_word(idx), 4'hF, rd);
            model[i] = fill_word(idx);
        end
        for (int n = 0; n < mem_ops; n++) begin
            idx = 8'($urandom_range(0, 255));
            if ($urandom_range(0, 1) == 1) begin
                wd = $urandom;
                st = 4'($urandom_range(1, 15));
                bus_access({22'b0, idx, 2'b00}, wd, st, rd);
                for (int b = 0; b < soc_pkg::strb_w; b++) begin
                    if (st[b]) begin
                        model[idx][8*b +: 8] = wd[8*b +: 8];
                    end
                end
            end else begin
                bus_access({22'b0, idx, 2'b00}, '0, '0, rd);
                check_word(rd, model[idx], "rdata (memory)");
            end
        end

        // led register
        for (int n = 0; n < 8; n++) begin
            bval = 8'($urandom_range(0, 255));
            wd   = {24'($urandom), bval};
            bus_access(soc_pkg::led_addr, wd, 4'($urandom_range(1, 15)), rd);
            check_led(led, bval, "led");
            bus_access(soc_pkg::led_addr, '0, '0, rd);
            check_word(rd, 32'd0, "rdata (led)");
            check_led(led, bval, "led");
        end

        // frequency word and unmapped space
        bus_access(soc_pkg::freq_addr, '0, '0, rd);
        check_word(rd, soc_pkg::system_clk_hz, "rdata (freq)");
        for (int n = 0; n < 20; n++) begin
            bus_access(pick_unmapped_addr(), '0, '0, rd);
            check_word(rd, 32'd0, "rdata (unmapped)");
        end

        // uart loopback
        for (int n = 0; n < uart_bytes; n++) begin
            bval = 8'($urandom_range(0, 255));
            bus_access(soc_pkg::uart_tx_addr, {24'b0, bval}, 4'h1, rd);
            polls = 0;
            do begin
                bus_access(soc_pkg::uart_lsr_addr, '0, '0, rd);
                polls++;
            end while (!(((rd & soc_pkg::lsr_tx_idle_bits) == soc_pkg::lsr_tx_idle_bits) &&
                         rd[soc_pkg::lsr_rx_avail_bit]) && polls < poll_limit);
            if (polls >= poll_limit) begin
                other_errors++;
                $display("error at %0t: status never showed tx idle and rx data for byte %h",
                         $time, bval);
            end
            bus_access(soc_pkg::uart_tx_addr, '0, '0, rd);
            check_word(rd, {24'b0, bval}, "rdata (uart rx)");
            bus_access(soc_pkg::uart_lsr_addr, '0, '0, rd);
            check_word(rd, soc_pkg::lsr_tx_idle_bits, "rdata (uart lsr)");
            bus_access(soc_pkg::uart_tx_addr, '0, '0, rd);
            check_word(rd, soc_pkg::rx_empty_word, "rdata (uart rx empty)");
        end

        total = word_errors + led_errors + latency_errors + other_errors;
        $display("errors: word %0d, led %0d, latency %0d, other %0d",
                 word_errors, led_errors, latency_errors, other_errors);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
design/soc_pkg.sv
design/soc_bus_decode.sv
design/soc_bram.sv
design/soc_uart_tx.sv
design/soc_uart_rx.sv
design/soc_io_regs.sv
design/soc_top.sv
testbench/tb_clock.sv
testbench/tb_soc_assert.sv
testbench/tb_soc.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_soc -f sources.f -o tb_soc

out=$(./obj_dir/tb_soc)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
